/* fetch_unit.f */
hw/fetch_pkg.sv
hw/b_predictor.sv
hw/npc.sv
hw/fetch_stage.sv
hw/fetch_unit.sv
tests/fetch_unit_asserts.sv
tests/tb_fetch_unit.sv

/* tests/tb_fetch_unit.sv */
module tb_fetch_unit;

  import fetch_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_CYCLES   = 4000;
  localparam int TIMEOUT      = (RESET_CYCLES + NUM_CYCLES + 4) * CLK_PERIOD + 2000;

  logic       clk;
  logic       rst;
  logic       stall;
  logic       exception_pc_ena;
  word_t      exception_pc;
  id2_jmp_t   id2;
  fetch_pkt_t fetch;
  logic       flush_req;
  logic       flush_is_jmp;
  stat_t      branch_total;
  stat_t      branch_miss;

  logic [31:0] lfsr;
  int          cycle;
  int          error_count;
  int          check_count;
  int          hit_count;
  int          flush_count;
  int          exc_count;
  int          assert_fails;

  // reference model state.
  logic       m_valid  [BTB_ENTRIES];
  btb_tag_t   m_tag    [BTB_ENTRIES];
  word_t      m_target [BTB_ENTRIES];
  ctr_t       m_ctr    [BTB_ENTRIES];
  word_t      m_pc;
  fetch_pkt_t m_fetch;
  stat_t      m_total;
  stat_t      m_miss;

  // expectations for the coming edge.
  logic  e_jmp;
  logic  e_taken;
  logic  e_flush;
  logic  e_hit;
  word_t e_target;
  word_t e_next;

  fetch_unit fetch_unit_i (
    .clk              (clk),
    .rst              (rst),
    .stall            (stall),
    .id2              (id2),
    .exception_pc_ena (exception_pc_ena),
    .exception_pc     (exception_pc),
    .fetch            (fetch),
    .flush_req        (flush_req),
    .flush_is_jmp     (flush_is_jmp),
    .branch_total     (branch_total),
    .branch_miss      (branch_miss)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // fibonacci lfsr on x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // a small window under two tags keeps fetch revisiting btb entries.
  function automatic word_t window_addr();
    word_t       base;
    logic [31:0] off;
    base = (take_bits(3) == 0) ? 32'h8000_0000 : RESET_PC;
    off  = take_bits(6);
    return base + (off << 2);
  endfunction

  function automatic logic branch_taken(input id2_jmp_t j);
    logic c;
    case (j.branch_sel)
      BR_BEQ:             c = (j.rs_data == j.rt_data);
      BR_BNE:             c = (j.rs_data != j.rt_data);
      BR_BGEZ, BR_BGEZAL: c = ($signed(j.rs_data) >= 0);
      BR_BGTZ:            c = ($signed(j.rs_data) > 0);
      BR_BLEZ:            c = ($signed(j.rs_data) <= 0);
      BR_BLTZ, BR_BLTZAL: c = ($signed(j.rs_data) < 0);
      default:            c = 1'b0;
    endcase
    return j.is_jr || j.is_j_imme || (j.is_branch && c);
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED cycle %0d %s expected %h actual %h",
               cycle, what, expected, actual);
    end
  endtask

  task automatic drive_inputs();
    logic [2:0] kind;
    logic [1:0] mode;
    logic       t;
    stall            = (take_bits(3) == 0);
    exception_pc_ena = (take_bits(5) == 0);
    exception_pc     = window_addr();
    kind = 3'(take_bits(3)); // 0..1 none, 2..5 branch, 6 jr, 7 j.
    id2 = '0;
    id2.pc            = window_addr();
    id2.is_branch     = (kind >= 3'd2) && (kind <= 3'd5);
    id2.is_jr         = (kind == 3'd6);
    id2.is_j_imme     = (kind == 3'd7);
    id2.in_delay_slot = (take_bits(1) != 0);
    if (take_bits(3) == 0) begin
      id2.branch_sel = branch_sel_t'(take_bits(3) | 32'd8); // never-taken codes.
    end else begin
      id2.branch_sel = branch_sel_t'(take_bits(3));
    end
    mode = 2'(take_bits(2));
    id2.rs_data = take_bits(32);
    id2.rt_data = take_bits(32);
    case (mode)
      2'd1:    id2.rt_data = id2.rs_data;
      2'd2:    id2.rs_data = '0;
      2'd3:    id2.rs_data[31] = 1'b1;
      default: ;
    endcase
    id2.jmp_target = window_addr();
    t = branch_taken(id2);
    if (take_bits(2) != 0) begin
      id2.pred_taken  = t;
      id2.pred_target = id2.jmp_target;
    end else begin
      id2.pred_taken  = (take_bits(1) != 0);
      id2.pred_target = take_bits(1) ? id2.jmp_target : window_addr();
    end
  endtask

  task automatic compute_expected();
    logic     mis;
    btb_idx_t idx;
    word_t    flush_pc;
    e_jmp   = id2.is_branch || id2.is_jr || id2.is_j_imme;
    e_taken = branch_taken(id2);
    mis     = (e_taken != id2.pred_taken) ||
              (e_taken && (id2.jmp_target != id2.pred_target));
    e_flush = e_jmp ? mis : (id2.pred_taken && !id2.in_delay_slot);
    idx      = m_pc[7:2];
    e_hit    = m_valid[idx] && (m_tag[idx] == m_pc[31:8]) && (m_ctr[idx] >= 2'd2);
    e_target = m_target[idx];
    if (!e_jmp) begin
      flush_pc = id2.pc + 32'd4;
    end else if (e_taken) begin
      flush_pc = id2.jmp_target;
    end else begin
      flush_pc = id2.pc + 32'd8;
    end
    if (exception_pc_ena) begin
      e_next = exception_pc;
    end else if (e_flush) begin
      e_next = flush_pc;
    end else if (e_hit) begin
      e_next = e_target;
    end else begin
      e_next = m_pc[2] ? m_pc + 32'd4 : m_pc + 32'd8;
    end
    hit_count   += e_hit;
    flush_count += e_flush;
    exc_count   += exception_pc_ena;
  endtask

  task automatic check_outputs();
    check_value("flush_req", e_flush, flush_req);
    check_value("flush_is_jmp", e_jmp, flush_is_jmp);
    check_value("fetch.valid", m_fetch.valid, fetch.valid);
    if (m_fetch.valid) begin
      check_value("fetch.pc", m_fetch.pc, fetch.pc);
      check_value("fetch.pred_taken", m_fetch.pred_taken, fetch.pred_taken);
      if (m_fetch.pred_taken) begin
        check_value("fetch.pred_target", m_fetch.pred_target, fetch.pred_target);
      end
    end
    check_value("branch_total", m_total, branch_total);
    check_value("branch_miss", m_miss, branch_miss);
  endtask

  task automatic advance_model();
    btb_idx_t idx;
    btb_tag_t tag;
    logic     hit;
    if (!stall || exception_pc_ena) begin
      m_fetch.pc          = m_pc;
      m_fetch.pred_taken  = e_hit;
      m_fetch.pred_target = e_target;
      m_fetch.valid       = !(e_flush || exception_pc_ena);
      m_pc                = e_next;
    end
    if (!stall) begin
      if (e_jmp) m_total = m_total + 1;
      if (e_flush) m_miss = m_miss + 1;
      if (e_jmp) begin
        idx = id2.pc[7:2];
        tag = id2.pc[31:8];
        hit = m_valid[idx] && (m_tag[idx] == tag);
        if (e_taken) begin
          if (!hit) begin
            m_ctr[idx] = 2'd2;
          end else if (m_ctr[idx] != 2'd3) begin
            m_ctr[idx] = m_ctr[idx] + 2'd1;
          end
          m_valid[idx]  = 1'b1;
          m_tag[idx]    = tag;
          m_target[idx] = id2.jmp_target;
        end else if (hit && (m_ctr[idx] != 2'd0)) begin
          m_ctr[idx] = m_ctr[idx] - 2'd1;
        end
      end
    end
  endtask

  initial begin
    #(TIMEOUT);
    $display("timeout, the run did not finish within %0d time units", TIMEOUT);
    $display("Test failures found");
    $finish;
  end

  initial begin
    clk              = 1'b0;
    rst              = 1'b1;
    stall            = 1'b0;
    exception_pc_ena = 1'b0;
    exception_pc     = '0;
    id2              = '0;
    lfsr             = 32'd7;
    error_count      = 0;
    check_count      = 0;
    hit_count        = 0;
    flush_count      = 0;
    exc_count        = 0;
    cycle            = 0;
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      m_valid[i] = 1'b0;
    end
    m_pc    = RESET_PC;
    m_fetch = '0;
    m_total = '0;
    m_miss  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (cycle = 0; cycle < NUM_CYCLES; cycle++) begin
      drive_inputs();
      #(CLK_PERIOD / 4); // sample well before the rising edge.
      compute_expected();
      check_outputs();
      @(posedge clk);
      advance_model();
      @(negedge clk);
    end
    if (hit_count == 0) begin
      error_count++;
      $display("no fetch ever hit the BTB, prediction path not exercised");
    end
    if (flush_count == 0 || exc_count == 0) begin
      error_count++;
      $display("the run saw no flush or no exception redirect");
    end
    assert_fails = fetch_unit_i.fetch_unit_asserts_i.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d, btb hits %0d, flushes %0d",
             check_count, error_count, assert_fails, hit_count, flush_count);
    if (error_count == 0 && assert_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* tests/fetch_unit_asserts.sv */
module fetch_unit_asserts (
  input logic                  clk,
  input logic                  rst,
  input logic                  stall,
  input logic                  exception_pc_ena,
  input logic                  flush_req,
  input logic                  flush_is_jmp,
  input fetch_pkg::id2_jmp_t   id2,
  input fetch_pkg::word_t      pc,
  input fetch_pkg::fetch_pkt_t fetch
);

  int fail_count; // read by the testbench at the end.

  initial fail_count = 0;

  flush_kind_a: assert property (@(posedge clk) disable iff (rst)
    flush_is_jmp |-> (id2.is_branch || id2.is_jr || id2.is_j_imme))
    else begin
      fail_count++;
      $error("flush_is_jmp raised without a jump in id2");
    end

  // only an exception moves pc through a stall.
  stall_hold_a: assert property (@(posedge clk) disable iff (rst)
    (stall && !exception_pc_ena) |=> $stable(pc))
    else begin
      fail_count++;
      $error("pc changed while stalled");
    end

  reset_kill_a: assert property (@(posedge clk) rst |=> !fetch.valid)
    else begin
      fail_count++;
      $error("fetch packet valid right after reset");
    end

  flush_kill_a: assert property (@(posedge clk) disable iff (rst)
    (flush_req && !stall) |=> !fetch.valid)
    else begin
      fail_count++;
      $error("wrong-path fetch packet not killed after a flush");
    end

endmodule

bind fetch_unit fetch_unit_asserts fetch_unit_asserts_i (
  .clk              (clk),
  .rst              (rst),
  .stall            (stall),
  .exception_pc_ena (exception_pc_ena),
  .flush_req        (flush_req),
  .flush_is_jmp     (flush_is_jmp),
  .id2              (id2),
  .pc               (pc),
  .fetch            (fetch)
);

/* hw/fetch_unit.sv */
module fetch_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  stall,
  input  fetch_pkg::id2_jmp_t   id2,
  input  logic                  exception_pc_ena,
  input  fetch_pkg::word_t      exception_pc,
  output fetch_pkg::fetch_pkt_t fetch,
  output logic                  flush_req,
  output logic                  flush_is_jmp,
  output fetch_pkg::stat_t      branch_total,
  output fetch_pkg::stat_t      branch_miss
);

  import fetch_pkg::*;

  word_t pc;
  word_t next_pc;
  logic  pc_pred_taken;
  word_t pc_pred_target;

  fetch_stage fetch_stage_i (
    .clk              (clk),
    .rst              (rst),
    .stall            (stall),
    .next_pc          (next_pc),
    .flush_req        (flush_req),
    .exception_pc_ena (exception_pc_ena),
    .pred_taken       (pc_pred_taken),
    .pred_target      (pc_pred_target),
    .pc               (pc),
    .fetch            (fetch)
  );

  npc npc_i (
    .clk              (clk),
    .rst              (rst),
    .stall            (stall),
    .id2              (id2),
    .exception_pc_ena (exception_pc_ena),
    .exception_pc     (exception_pc),
    .pc               (pc),
    .flush_req        (flush_req),
    .flush_is_jmp     (flush_is_jmp),
    .pc_pred_taken    (pc_pred_taken),
    .pc_pred_target   (pc_pred_target),
    .next_pc          (next_pc),
    .branch_total     (branch_total),
    .branch_miss      (branch_miss)
  );

endmodule

/* hw/fetch_stage.sv */
module fetch_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  stall,
  input  fetch_pkg::word_t      next_pc,
  input  logic                  flush_req,
  input  logic                  exception_pc_ena,
  input  logic                  pred_taken,
  input  fetch_pkg::word_t      pred_target,
  output fetch_pkg::word_t      pc,
  output fetch_pkg::fetch_pkt_t fetch
);

  import fetch_pkg::*;

  logic load;
  logic kill;

  // an exception redirect goes through a stall.
  assign load = ~stall | exception_pc_ena;

  // the fetch in flight is on the wrong path.
  assign kill = flush_req | exception_pc_ena;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (load) begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch.valid <= 1'b0;
    end else if (load) begin
      fetch.pc          <= pc;
      fetch.pred_taken  <= pred_taken;
      fetch.pred_target <= pred_target;
      fetch.valid       <= ~kill;
    end
  end

endmodule

/* hw/npc.sv */
module npc (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall,
  input  fetch_pkg::id2_jmp_t  id2,
  input  logic                 exception_pc_ena,
  input  fetch_pkg::word_t     exception_pc,
  input  fetch_pkg::word_t     pc,
  output logic                 flush_req,
  output logic                 flush_is_jmp,
  output logic                 pc_pred_taken,
  output fetch_pkg::word_t     pc_pred_target,
  output fetch_pkg::word_t     next_pc,
  output fetch_pkg::stat_t     branch_total,
  output fetch_pkg::stat_t     branch_miss
);

  import fetch_pkg::*;

  logic  is_jmp;
  logic  cond;
  logic  taken;
  logic  mispredict;
  logic  rs_neg;
  logic  rs_zero;
  word_t seq_pc;
  word_t flush_pc;

  assign is_jmp  = id2.is_branch | id2.is_jr | id2.is_j_imme;
  assign rs_neg  = id2.rs_data[31];
  assign rs_zero = (id2.rs_data == '0);

  // codes 8..15 are never taken.
  always_comb begin
    case (id2.branch_sel)
      BR_BEQ:    cond = (id2.rs_data == id2.rt_data);
      BR_BNE:    cond = (id2.rs_data != id2.rt_data);
      BR_BGEZ:   cond = ~rs_neg;
      BR_BGTZ:   cond = ~rs_neg & ~rs_zero;
      BR_BLEZ:   cond = rs_neg | rs_zero;
      BR_BLTZ:   cond = rs_neg;
      BR_BGEZAL: cond = ~rs_neg;
      BR_BLTZAL: cond = rs_neg;
      default:   cond = 1'b0;
    endcase
  end

  assign taken = id2.is_jr | id2.is_j_imme | (id2.is_branch & cond);

  assign mispredict =
    (taken & ~id2.pred_taken) |
    (taken & id2.pred_taken & (id2.pred_target != id2.jmp_target)) |
    (~taken & id2.pred_taken);

  // without a jump, a set pred_taken is a stale btb hit.
  assign flush_req    = is_jmp ? mispredict : (id2.pred_taken & ~id2.in_delay_slot);
  assign flush_is_jmp = is_jmp;

  b_predictor b_predictor_i (
    .clk         (clk),
    .rst         (rst),
    .pc          (pc),
    .pred_taken  (pc_pred_taken),
    .pred_target (pc_pred_target),
    .update      (is_jmp & ~stall),
    .update_pc   (id2.pc),
    .act_taken   (taken),
    .act_target  (id2.jmp_target)
  );

  // an odd slot of an aligned pair only needs +4.
  assign seq_pc = pc[2] ? pc + 32'd4 : pc + 32'd8;

  always_comb begin
    if (!is_jmp) begin
      flush_pc = id2.pc + 32'd4;
    end else if (taken) begin
      flush_pc = id2.jmp_target;
    end else begin
      flush_pc = id2.pc + 32'd8; // skip the delay slot.
    end
  end

  always_comb begin
    if (exception_pc_ena) begin
      next_pc = exception_pc;
    end else if (flush_req) begin
      next_pc = flush_pc;
    end else if (pc_pred_taken) begin
      next_pc = pc_pred_target;
    end else begin
      next_pc = seq_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      branch_total <= '0;
      branch_miss  <= '0;
    end else if (!stall) begin
      if (is_jmp) begin
        branch_total <= branch_total + 32'd1;
      end
      if (flush_req) begin
        branch_miss <= branch_miss + 32'd1;
      end
    end
  end

endmodule

/* hw/b_predictor.sv */
module b_predictor (
  input  logic             clk,
  input  logic             rst,
  input  fetch_pkg::word_t pc,
  output logic             pred_taken,
  output fetch_pkg::word_t pred_target,
  input  logic             update,
  input  fetch_pkg::word_t update_pc,
  input  logic             act_taken,
  input  fetch_pkg::word_t act_target
);

  import fetch_pkg::*;

  logic [BTB_ENTRIES-1:0] valid;
  btb_tag_t               tag_mem    [BTB_ENTRIES];
  word_t                  target_mem [BTB_ENTRIES];
  ctr_t                   ctr_mem    [BTB_ENTRIES];

  btb_idx_t rd_idx;
  btb_tag_t rd_tag;
  btb_idx_t wr_idx;
  btb_tag_t wr_tag;
  logic     rd_hit;
  logic     wr_hit;

  assign rd_idx = pc[BTB_IDX_W+1:2];
  assign rd_tag = pc[31:BTB_IDX_W+2];
  assign wr_idx = update_pc[BTB_IDX_W+1:2];
  assign wr_tag = update_pc[31:BTB_IDX_W+2];

  // lookup.
  assign rd_hit      = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign pred_taken  = rd_hit && (ctr_mem[rd_idx] >= 2'd2);
  assign pred_target = target_mem[rd_idx];

  assign wr_hit = valid[wr_idx] && (tag_mem[wr_idx] == wr_tag);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (update && act_taken) begin
      valid[wr_idx] <= 1'b1; // a taken miss allocates.
    end
  end

  always_ff @(posedge clk) begin
    if (update) begin
      if (act_taken) begin
        tag_mem[wr_idx]    <= wr_tag;
        target_mem[wr_idx] <= act_target;
        if (wr_hit) begin
          if (ctr_mem[wr_idx] != 2'd3) begin
            ctr_mem[wr_idx] <= ctr_mem[wr_idx] + 2'd1;
          end
        end else begin
          ctr_mem[wr_idx] <= 2'd2; // new entry starts weakly taken.
        end
      end else if (wr_hit && (ctr_mem[wr_idx] != 2'd0)) begin
        ctr_mem[wr_idx] <= ctr_mem[wr_idx] - 2'd1;
      end
    end
  end

endmodule

/* hw/fetch_pkg.sv */
package fetch_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  branch_sel_t;
  typedef logic [31:0] stat_t;
  typedef logic [1:0]  ctr_t; // 2-bit saturating counter.

  // branch kinds as decoded in id.
  localparam branch_sel_t BR_BEQ    = 4'd0;
  localparam branch_sel_t BR_BNE    = 4'd1;
  localparam branch_sel_t BR_BGEZ   = 4'd2;
  localparam branch_sel_t BR_BGTZ   = 4'd3;
  localparam branch_sel_t BR_BLEZ   = 4'd4;
  localparam branch_sel_t BR_BLTZ   = 4'd5;
  localparam branch_sel_t BR_BGEZAL = 4'd6;
  localparam branch_sel_t BR_BLTZAL = 4'd7;

  // btb index is pc[7:2] and the tag is pc[31:8].
  localparam int BTB_ENTRIES = 64;
  localparam int BTB_IDX_W   = 6;
  localparam int BTB_TAG_W   = 24;

  typedef logic [BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [BTB_TAG_W-1:0] btb_tag_t;

  localparam word_t RESET_PC = 32'hbfc0_0000;

  typedef struct packed {
    word_t pc;
    logic  pred_taken;
    word_t pred_target;
    logic  valid;
  } fetch_pkt_t;

  // jump or branch sitting in id2.
  typedef struct packed {
    word_t       pc;
    word_t       rs_data;
    word_t       rt_data;
    logic        is_branch;
    logic        is_jr;
    logic        is_j_imme;
    logic        in_delay_slot;
    branch_sel_t branch_sel;
    word_t       jmp_target;
    logic        pred_taken;   // prediction carried from fetch.
    word_t       pred_target;
  } id2_jmp_t;

endpackage
